// File: logic/cache_pkg.sv
// Instruction cache geometry

package cache_pkg;

    // ----------------------------------------------------------
    // Address layout.
    // ----------------------------------------------------------

    // Fetch address and instruction word widths.
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // Byte offset inside a word.
    localparam int BYTE_OFF_W = 2;

    // Word offset inside a line.
    localparam int WORD_OFF_W = 2;

    // Line index, 16 lines.
    localparam int INDEX_W = 4;

    // Whatever is left above the index is tag.
    localparam int TAG_W = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

    // ----------------------------------------------------------
    // Array geometry.
    // ----------------------------------------------------------

    localparam int LINES          = 1 << INDEX_W;
    localparam int WORDS_PER_LINE = 1 << WORD_OFF_W;

    // Address field types.
    typedef logic [ADDR_W     - 1:0] t_addr;
    typedef logic [TAG_W      - 1:0] t_tag;
    typedef logic [INDEX_W    - 1:0] t_index;
    typedef logic [WORD_OFF_W - 1:0] t_word_off;
    typedef logic [WORD_W     - 1:0] t_word;

endpackage

// File: logic/mem_pkg.sv
// Refill memory port definitions

package mem_pkg;

    // Words per refill burst, one full line.
    localparam int BURST_LEN = 4;

    // Credits granted by the memory at reset.
    localparam int CREDIT_MAX = 2;
    localparam int CREDIT_W   = 2;

    // Line address is tag plus index.
    localparam int LINE_ADDR_W = 28;

    // ----------------------------------------------------------
    // Types.
    // ----------------------------------------------------------

    typedef logic [CREDIT_W    - 1:0] t_credit;
    typedef logic [LINE_ADDR_W - 1:0] t_line_addr;

endpackage

// File: logic/instr_cache_fsm.sv
// Instruction cache control FSM

`timescale 1ns/1ps

module instr_cache_fsm (
    // Clock and reset.
    input  logic clk,
    input  logic arstn,

    // Status inputs.
    input  logic i_start_check,
    input  logic i_hit,
    input  logic i_r_last,

    // Control outputs.
    output logic o_stall,
    output logic o_instr_write_en,
    output logic o_start_read,
    output logic o_instr_valid
);

    // ----------------------------------------------------------
    // State register.
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        IDLE        = 2'b00,
        COMPARE_TAG = 2'b01,
        ALLOCATE    = 2'b10
    } t_state;

    t_state state;
    t_state state_next;

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Next state.
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_start_check) begin
                    state_next = COMPARE_TAG;
                end
            end
            COMPARE_TAG: begin
                // A miss goes off to fetch the line.
                if (i_hit) begin
                    state_next = IDLE;
                end else begin
                    state_next = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (i_r_last) begin
                    state_next = COMPARE_TAG;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // ----------------------------------------------------------
    // Outputs.
    // ----------------------------------------------------------

    // Only a hit in tag compare releases the core.
    assign o_instr_valid    = (state == COMPARE_TAG) && i_hit;
    assign o_stall          = !o_instr_valid;
    assign o_instr_write_en = (state == ALLOCATE);
    assign o_start_read     = (state == ALLOCATE);

    // The last refill word only arrives while a line is allocated.
    a_rlast_in_alloc: assert property (
        @(posedge clk) disable iff (!arstn)
        i_r_last |-> (state == ALLOCATE)
    ) else $error("Last refill word arrived outside allocate.");

endmodule

// File: logic/refill_tracker.sv
// Refill credit and word tracker

`timescale 1ns/1ps

module refill_tracker (
    // Clock and reset.
    input  logic                 clk,
    input  logic                 arstn,

    // From the FSM.
    input  logic                 i_start_read,
    input  logic                 i_instr_write_en,

    // Memory port.
    input  logic                 i_mem_credit,
    input  logic                 i_mem_rvalid,
    input  cache_pkg::t_addr     i_miss_addr,
    output logic                 o_mem_req,
    output mem_pkg::t_line_addr  o_mem_line_addr,

    // Refill write offset.
    output cache_pkg::t_word_off o_word_off
);

    mem_pkg::t_credit     credit_cnt;
    logic                 req_sent;
    cache_pkg::t_word_off word_cnt;

    // One request per allocate, and only with a credit in hand.
    assign o_mem_req = i_start_read && !req_sent && (credit_cnt != '0);

    // Line address drops the word and byte offsets.
    assign o_mem_line_addr = i_miss_addr[cache_pkg::ADDR_W - 1 :
                                         cache_pkg::WORD_OFF_W + cache_pkg::BYTE_OFF_W];

    assign o_word_off = word_cnt;

    // ----------------------------------------------------------
    // Credit counter.
    // ----------------------------------------------------------

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            credit_cnt <= mem_pkg::t_credit'(mem_pkg::CREDIT_MAX);
        end else if (i_mem_credit && !o_mem_req) begin
            credit_cnt <= credit_cnt + 1'b1;
        end else if (o_mem_req && !i_mem_credit) begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    // Request flag, dropped once the FSM leaves allocate.
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            req_sent <= 1'b0;
        end else if (!i_start_read) begin
            req_sent <= 1'b0;
        end else if (o_mem_req) begin
            req_sent <= 1'b1;
        end
    end

    // Burst word counter.
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            word_cnt <= '0;
        end else if (!i_instr_write_en) begin
            word_cnt <= '0;
        end else if (i_mem_rvalid) begin
            if (word_cnt == cache_pkg::t_word_off'(mem_pkg::BURST_LEN - 1)) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // The memory never hands back more credits than it granted.
    a_credit_max: assert property (
        @(posedge clk) disable iff (!arstn)
        credit_cnt <= mem_pkg::t_credit'(mem_pkg::CREDIT_MAX)
    ) else $error("Credit count above the memory limit.");

    // Refill words only follow the request of this allocate.
    a_rdata_after_req: assert property (
        @(posedge clk) disable iff (!arstn)
        i_mem_rvalid |-> (i_instr_write_en && req_sent)
    ) else $error("Refill word arrived without an outstanding request.");

endmodule

// File: logic/tag_array.sv
// Tag and valid storage with hit compare

`timescale 1ns/1ps

module tag_array (
    // Clock and reset.
    input  logic              clk,
    input  logic              arstn,

    // Lookup and fill.
    input  cache_pkg::t_index i_index,
    input  cache_pkg::t_tag   i_tag,
    input  logic              i_fill_done,

    // Lookup result.
    output logic              o_hit
);

    // ----------------------------------------------------------
    // Storage.
    // ----------------------------------------------------------

    logic [cache_pkg::LINES - 1:0] valid;
    cache_pkg::t_tag               tags [cache_pkg::LINES];

    // Valid bits are the only state that must start known.
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            valid <= '0;
        end else if (i_fill_done) begin
            valid[i_index] <= 1'b1;
        end
    end

    // Tag written with the last refill word.
    always_ff @(posedge clk) begin
        if (i_fill_done) begin
            tags[i_index] <= i_tag;
        end
    end

    // ----------------------------------------------------------
    // Hit compare.
    // ----------------------------------------------------------

    assign o_hit = valid[i_index] && (tags[i_index] == i_tag);

    // A refill only ever lands on a line that misses.
    a_fill_on_miss: assert property (
        @(posedge clk) disable iff (!arstn)
        i_fill_done |-> !o_hit
    ) else $error("Refill completed on a line that already hits.");

endmodule

// File: logic/data_array.sv
// Instruction word storage

`timescale 1ns/1ps

module data_array (
    input  logic                 clk,

    // Line select from the fetch address.
    input  cache_pkg::t_index    i_index,

    // Fetch read.
    input  cache_pkg::t_word_off i_rd_off,

    // Refill write.
    input  cache_pkg::t_word_off i_wr_off,
    input  logic                 i_wr_en,
    input  cache_pkg::t_word     i_wr_data,

    output cache_pkg::t_word     o_rd_data
);

    // ----------------------------------------------------------
    // Word array.
    // ----------------------------------------------------------

    cache_pkg::t_word words [cache_pkg::LINES][cache_pkg::WORDS_PER_LINE];

    // One refill word per strobe.
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            words[i_index][i_wr_off] <= i_wr_data;
        end
    end

    // Read path is combinational, so a hit answers in tag compare.
    assign o_rd_data = words[i_index][i_rd_off];

endmodule

// File: logic/instr_cache_top.sv
// Direct-mapped instruction cache

`timescale 1ns/1ps

module instr_cache_top (
    // Clock and reset.
    input  logic                clk,
    input  logic                arstn,

    // Fetch port.
    input  logic                i_fetch_valid,
    input  cache_pkg::t_addr    i_fetch_addr,
    output logic                o_stall,
    output logic                o_instr_valid,
    output cache_pkg::t_word    o_instr,

    // Memory port.
    input  logic                i_mem_credit,
    input  logic                i_mem_rvalid,
    input  cache_pkg::t_word    i_mem_rdata,
    input  logic                i_mem_rlast,
    output logic                o_mem_req,
    output mem_pkg::t_line_addr o_mem_line_addr
);

    // ----------------------------------------------------------
    // Address split and strobes.
    // ----------------------------------------------------------

    localparam int WORD_LSB  = cache_pkg::BYTE_OFF_W;
    localparam int INDEX_LSB = WORD_LSB + cache_pkg::WORD_OFF_W;
    localparam int TAG_LSB   = INDEX_LSB + cache_pkg::INDEX_W;

    cache_pkg::t_tag      fetch_tag;
    cache_pkg::t_index    fetch_index;
    cache_pkg::t_word_off fetch_word_off;
    cache_pkg::t_word_off fill_word_off;

    logic hit;
    logic start_read;
    logic instr_write_en;
    logic fill_wr;
    logic fill_done;
    logic rlast_valid;

    assign fetch_tag      = i_fetch_addr[cache_pkg::ADDR_W - 1 : TAG_LSB];
    assign fetch_index    = i_fetch_addr[TAG_LSB - 1 : INDEX_LSB];
    assign fetch_word_off = i_fetch_addr[INDEX_LSB - 1 : WORD_LSB];

    assign rlast_valid = i_mem_rvalid && i_mem_rlast;
    assign fill_wr     = instr_write_en && i_mem_rvalid;
    assign fill_done   = fill_wr && i_mem_rlast;

    // ----------------------------------------------------------
    // Instances.
    // ----------------------------------------------------------

    instr_cache_fsm u_fsm (
        .clk              (clk),
        .arstn            (arstn),
        .i_start_check    (i_fetch_valid),
        .i_hit            (hit),
        .i_r_last         (rlast_valid),
        .o_stall          (o_stall),
        .o_instr_write_en (instr_write_en),
        .o_start_read     (start_read),
        .o_instr_valid    (o_instr_valid)
    );

    refill_tracker u_tracker (
        .clk              (clk),
        .arstn            (arstn),
        .i_start_read     (start_read),
        .i_instr_write_en (instr_write_en),
        .i_mem_credit     (i_mem_credit),
        .i_mem_rvalid     (i_mem_rvalid),
        .i_miss_addr      (i_fetch_addr),
        .o_mem_req        (o_mem_req),
        .o_mem_line_addr  (o_mem_line_addr),
        .o_word_off       (fill_word_off)
    );

    tag_array u_tags (
        .clk         (clk),
        .arstn       (arstn),
        .i_index     (fetch_index),
        .i_tag       (fetch_tag),
        .i_fill_done (fill_done),
        .o_hit       (hit)
    );

    data_array u_data (
        .clk       (clk),
        .i_index   (fetch_index),
        .i_rd_off  (fetch_word_off),
        .i_wr_off  (fill_word_off),
        .i_wr_en   (fill_wr),
        .i_wr_data (i_mem_rdata),
        .o_rd_data (o_instr)
    );

endmodule

// File: verification/mem_model.sv
// Refill memory responder

`timescale 1ns/1ps

module mem_model (
    input  logic                clk,
    input  logic                arstn,
    input  logic                i_starve,
    input  logic                i_mem_req,
    input  mem_pkg::t_line_addr i_mem_line_addr,
    output logic                o_mem_credit,
    output logic                o_mem_rvalid,
    output cache_pkg::t_word    o_mem_rdata,
    output logic                o_mem_rlast,
    output int                  o_credits,
    output logic                o_overdraw
);

    int unsigned         lcg_state = 37;
    int                  cycle;
    int                  credits;
    int                  due [$];
    int                  due_idx;
    int                  burst_wait;
    int                  word_idx;
    logic                bursting;
    logic                overdraw;
    mem_pkg::t_line_addr line_q;

    assign o_credits  = credits;
    assign o_overdraw = overdraw;

    // Linear congruential generator for credit and burst delays.
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    always @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            cycle = 0;
            credits = mem_pkg::CREDIT_MAX;
            due.delete();
            bursting = 1'b0;
            overdraw = 1'b0;
            o_mem_credit <= 1'b0;
            o_mem_rvalid <= 1'b0;
            o_mem_rdata  <= '0;
            o_mem_rlast  <= 1'b0;
        end else begin
            cycle++;
            // Same view of the credit count as the cache holds.
            if (i_mem_req && credits == 0)
                overdraw = 1'b1;
            credits = credits + (o_mem_credit ? 1 : 0) - (i_mem_req ? 1 : 0);

            // ----------------------------------------------------------
            // Burst return, with random idle gaps.
            // ----------------------------------------------------------
            o_mem_rvalid <= 1'b0;
            o_mem_rlast  <= 1'b0;
            if (bursting) begin
                if (burst_wait > 0) begin
                    burst_wait--;
                end else if (lcg_next() % 4 != 0) begin
                    o_mem_rvalid <= 1'b1;
                    o_mem_rdata  <= {line_q, 2'(word_idx), 2'b00} ^ 32'hA5A5A5A5;
                    o_mem_rlast  <= (word_idx == mem_pkg::BURST_LEN - 1);
                    word_idx++;
                    if (word_idx == mem_pkg::BURST_LEN)
                        bursting = 1'b0;
                end
            end

            // New request starts a burst and schedules its credit.
            if (i_mem_req) begin
                line_q = i_mem_line_addr;
                bursting = 1'b1;
                word_idx = 0;
                burst_wait = 1 + int'(lcg_next() % 3);
                if (i_starve)
                    due.push_back(cycle + 60);
                else
                    due.push_back(cycle + 1 + int'(lcg_next() % 8));
            end

            // At most one credit pulse per cycle.
            o_mem_credit <= 1'b0;
            due_idx = -1;
            foreach (due[i]) begin
                if (due_idx < 0 && due[i] <= cycle)
                    due_idx = i;
            end
            if (due_idx >= 0) begin
                due.delete(due_idx);
                o_mem_credit <= 1'b1;
            end
        end
    end

endmodule

// File: verification/instr_cache_tb.sv
// Instruction cache testbench

`timescale 1ns/1ps

module instr_cache_tb;

    localparam int MAX_ROWS = 32;
    localparam int TIMEOUT  = 400;

    logic                clk = 1'b0;
    logic                arstn = 1'b1;
    logic                fetch_valid;
    cache_pkg::t_addr    fetch_addr;
    logic                starve;
    logic                stall;
    logic                instr_valid;
    cache_pkg::t_word    instr;
    logic                mem_credit;
    logic                mem_rvalid;
    cache_pkg::t_word    mem_rdata;
    logic                mem_rlast;
    logic                mem_req;
    mem_pkg::t_line_addr mem_line_addr;
    int                  model_credits;
    logic                overdraw;

    // Four columns per row: address, hit flag, word, starve mode.
    logic [31:0] stim [MAX_ROWS * 4];
    int          tests;
    int          failed;
    int          errors;
    int          err_mark;
    int          zero_credit_waits;
    logic        abort;

    always #20 clk = ~clk;

    instr_cache_top dut (
        .clk             (clk),
        .arstn           (arstn),
        .i_fetch_valid   (fetch_valid),
        .i_fetch_addr    (fetch_addr),
        .o_stall         (stall),
        .o_instr_valid   (instr_valid),
        .o_instr         (instr),
        .i_mem_credit    (mem_credit),
        .i_mem_rvalid    (mem_rvalid),
        .i_mem_rdata     (mem_rdata),
        .i_mem_rlast     (mem_rlast),
        .o_mem_req       (mem_req),
        .o_mem_line_addr (mem_line_addr)
    );

    mem_model u_mem (
        .clk             (clk),
        .arstn           (arstn),
        .i_starve        (starve),
        .i_mem_req       (mem_req),
        .i_mem_line_addr (mem_line_addr),
        .o_mem_credit    (mem_credit),
        .o_mem_rvalid    (mem_rvalid),
        .o_mem_rdata     (mem_rdata),
        .o_mem_rlast     (mem_rlast),
        .o_credits       (model_credits),
        .o_overdraw      (overdraw)
    );

    // ----------------------------------------------------------
    // Checks.
    // ----------------------------------------------------------

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("** Error: %s %s expected %h actual %h", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic expect_true(input string test, input string what, input logic ok);
        assert (ok === 1'b1) else begin
            $display("%s: %s", test, what);
            errors++;
        end
    endtask

    task automatic finish_test(input string test, input int err_before);
        tests++;
        if (errors != err_before)
            failed++;
        $display("%s: %s", test, (errors == err_before) ? "ok" : "failed");
    endtask

    // One fetch, held until the cache answers.
    task automatic run_row(input int row);
        string            name;
        cache_pkg::t_addr addr;
        logic             exp_hit;
        int               reqs;
        int               cycles;
        int               err_before;
        name = $sformatf("row %0d", row);
        addr = stim[row * 4];
        exp_hit = stim[row * 4 + 1][0];
        err_before = errors;
        reqs = 0;
        cycles = 0;
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        starve      <= stim[row * 4 + 3][0];
        @(posedge clk);
        fetch_valid <= 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (mem_req) begin
                reqs++;
                compare_value(name, "line address", {4'h0, addr[31:4]}, {4'h0, mem_line_addr});
            end
            if (!instr_valid)
                compare_value(name, "stall while waiting", 1, stall);
            // Waiting in allocate with no credit and no request.
            if (cycles > 1 && reqs == 0 && model_credits == 0)
                zero_credit_waits++;
        end while (!instr_valid && cycles < TIMEOUT);
        expect_true(name, "no instruction delivered before the timeout", instr_valid);
        abort = !instr_valid;
        compare_value(name, "word", stim[row * 4 + 2], instr);
        compare_value(name, "stall on delivery", 0, stall);
        compare_value(name, "requests", exp_hit ? 0 : 1, reqs);
        if (exp_hit)
            compare_value(name, "hit latency", 1, cycles);
        finish_test($sformatf("%s addr %h", name, addr), err_before);
    endtask

    initial begin
        fetch_valid = 1'b0;
        fetch_addr = '0;
        starve = 1'b0;
        arstn = 1'b0;
        abort = 1'b0;
        foreach (stim[i])
            stim[i] = '1;
        $readmemh("verification/instr_cache_stim.txt", stim);
        repeat (5) @(posedge clk);
        arstn <= 1'b1;

        @(negedge clk);
        expect_true("reset", "instruction valid is high after reset", !instr_valid);
        expect_true("reset", "memory request is high after reset", !mem_req);
        expect_true("reset", "stall is low after reset", stall);
        finish_test("reset", 0);

        for (int row = 0; row < MAX_ROWS && stim[row * 4] != 32'hFFFFFFFF && !abort; row++)
            run_row(row);

        err_mark = errors;
        expect_true("back_pressure", "no miss ever waited with zero credits",
                    zero_credit_waits > 0);
        expect_true("back_pressure", "a request was issued with zero credits", !overdraw);
        finish_test("back_pressure", err_mark);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && !abort)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: verification/instr_cache_stim.txt
// Columns: fetch address, expected hit (1) or miss (0), expected word,
// credit mode (0 short random delay, 1 starved credit return).
00001000 0 A5A5B5A5 0
00001004 1 A5A5B5A1 0
0000100C 1 A5A5B5A9 0
00002000 0 A5A585A5 0
00001008 0 A5A5B5AD 0
00002004 0 A5A585A1 0
00003010 0 A5A595B5 1
00003020 0 A5A59585 1
00003030 0 A5A59595 0
00003034 1 A5A59591 0
00003014 1 A5A595B1 0
00003028 1 A5A5958D 0
00004040 0 A5A5E5E5 0
0000404C 1 A5A5E5E9 0
00001000 0 A5A5B5A5 0
00001004 1 A5A5B5A1 0
00002000 0 A5A585A5 0
FFFFFFFF 0 00000000 0

// File: project.f
logic/cache_pkg.sv
logic/mem_pkg.sv
logic/instr_cache_fsm.sv
logic/refill_tracker.sv
logic/tag_array.sv
logic/data_array.sv
logic/instr_cache_top.sv
verification/mem_model.sv
verification/instr_cache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f project.f --top-module instr_cache_tb \
    || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/Vinstr_cache_tb)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
